/* Makefile */
# Verilator build and run of the processor testbench

VERILATOR ?= verilator
TOP       ?= tb_processor
LOG       ?= sim.log
FILELIST  ?= processor.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run into $(LOG) and search it for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG FILELIST BUILD_DIR"

test:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "test failed, see $(LOG)"; exit 1; }
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* alu.sv */
// Execute ALU
// add, sub, and, or, sll and sra on two words, plus the not-equal and
// signed less-than flags used to resolve bne and blt
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
    input  cpu_pkg::word_t    operand_a,
    input  cpu_pkg::word_t    operand_b,
    input  cpu_pkg::alu_fn_t  fn,
    input  cpu_pkg::reg_idx_t shamt,
    output cpu_pkg::word_t    result,
    output logic              not_equal,
    output logic              less_than
);

    always_comb begin
        case (fn)
            `ALU_ADD: result = operand_a + operand_b;
            `ALU_SUB: result = operand_a - operand_b;
            `ALU_AND: result = operand_a & operand_b;
            `ALU_OR:  result = operand_a | operand_b;
            // Shifts act on operand A by the shamt field
            `ALU_SLL: result = operand_a << shamt;
            `ALU_SRA: result = cpu_pkg::word_t'($signed(operand_a) >>> shamt);
            default:  result = '0;
        endcase
    end

    // Branch flags, independent of fn
    assign not_equal = (operand_a != operand_b);
    assign less_than = ($signed(operand_a) < $signed(operand_b));

endmodule

/* cpu_config.svh */
// CPU configuration
// Widths, instruction field positions, opcodes, ALU function codes and
// forward source codes for the five-stage word-addressed processor
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath and register index widths
`define CPU_XLEN      32
`define CPU_REG_BITS  5
`define CPU_OP_BITS   5
`define CPU_FN_BITS   5
`define CPU_FWD_BITS  2
`define CPU_IMM_BITS  17
`define CPU_TGT_BITS  27

// Low bit of each instruction field
`define FLD_OPCODE    27
`define FLD_RD        22
`define FLD_RS        17
`define FLD_RT        12
`define FLD_SHAMT     7
`define FLD_FN        2

// Opcodes
`define OP_ALU        5'b00000
`define OP_J          5'b00001
`define OP_BNE        5'b00010
`define OP_ADDI       5'b00101
`define OP_BLT        5'b00110
`define OP_SW         5'b00111
`define OP_LW         5'b01000

// R-type function field
`define ALU_ADD       5'd0
`define ALU_SUB       5'd1
`define ALU_AND       5'd2
`define ALU_OR        5'd3
`define ALU_SLL       5'd4
`define ALU_SRA       5'd5

// Execute operand sources
`define FWD_PIPE      2'd0
`define FWD_MEM       2'd1
`define FWD_WB        2'd2

`endif

/* cpu_pkg.sv */
// CPU shared types
// Word, register index, opcode, ALU function and forward select types
`include "cpu_config.svh"

package cpu_pkg;

    // Data, instruction and address word
    typedef logic [`CPU_XLEN-1:0] word_t;

    // Register file index, also used for the shift amount
    typedef logic [`CPU_REG_BITS-1:0] reg_idx_t;

    // Major opcode field
    typedef logic [`CPU_OP_BITS-1:0] opcode_t;

    // R-type function field
    typedef logic [`CPU_FN_BITS-1:0] alu_fn_t;

    // Execute operand source: pipeline value, memory forward or writeback forward
    typedef logic [`CPU_FWD_BITS-1:0] fwd_sel_t;

endpackage

/* decode_unit.sv */
// Decode stage
// Splits the instruction into fields, picks both register file read indices,
// sign-extends the immediate and decides whether the result is written back
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_unit (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::reg_idx_t read_reg_a,
    output cpu_pkg::reg_idx_t read_reg_b,
    output cpu_pkg::reg_idx_t dest_reg,
    output cpu_pkg::word_t    imm,
    output logic              write_en,
    output logic              is_load,
    output logic              is_store,
    output logic              is_branch
);

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    logic              is_alu;
    logic              is_addi;

    // Field extraction
    assign opcode = instr[`FLD_OPCODE +: `CPU_OP_BITS];
    assign rd     = instr[`FLD_RD +: `CPU_REG_BITS];
    assign rs     = instr[`FLD_RS +: `CPU_REG_BITS];
    assign rt     = instr[`FLD_RT +: `CPU_REG_BITS];

    // Instruction class
    assign is_alu    = (opcode == `OP_ALU);
    assign is_addi   = (opcode == `OP_ADDI);
    assign is_load   = (opcode == `OP_LW);
    assign is_store  = (opcode == `OP_SW);
    assign is_branch = (opcode == `OP_BNE) || (opcode == `OP_BLT);

    // Branches compare rd against rs, so rd goes out on port A
    assign read_reg_a = is_branch ? rd : rs;

    // Port B: rs for branches, store data register for sw, rt otherwise
    always_comb begin
        if (is_branch) begin
            read_reg_b = rs;
        end else if (is_store) begin
            read_reg_b = rd;
        end else begin
            read_reg_b = rt;
        end
    end

    assign dest_reg = rd;

    // 17-bit immediate, sign bit replicated up to the full word
    assign imm = {{(`CPU_XLEN - `CPU_IMM_BITS){instr[`CPU_IMM_BITS-1]}},
                  instr[`CPU_IMM_BITS-1:0]};

    // Only ALU, addi and lw write back, and never into r0
    assign write_en = (is_alu || is_addi || is_load) && (rd != '0);

endmodule

/* hazard_unit.sv */
// Hazard unit
// Picks forward sources for both execute operands, detects the load-use
// case that needs one bubble and flushes the front end on a redirect
`timescale 1ns/1ps
`include "cpu_config.svh"

module hazard_unit (
    input  cpu_pkg::reg_idx_t dec_rs,
    input  cpu_pkg::reg_idx_t dec_rt,
    input  cpu_pkg::reg_idx_t exe_rs,
    input  cpu_pkg::reg_idx_t exe_rt,
    input  cpu_pkg::reg_idx_t exe_rd,
    input  cpu_pkg::reg_idx_t mem_rd,
    input  cpu_pkg::reg_idx_t wb_rd,
    input  logic              dec_is_store,
    input  logic              exe_is_load,
    input  logic              mem_write_en,
    input  logic              wb_write_en,
    input  logic              redirect,
    output cpu_pkg::fwd_sel_t fwd_a,
    output cpu_pkg::fwd_sel_t fwd_b,
    output logic              stall,
    output logic              flush
);

    // Youngest writer wins, memory stage before writeback
    function automatic cpu_pkg::fwd_sel_t pick_source(input cpu_pkg::reg_idx_t src);
        if (mem_write_en && (mem_rd != '0) && (mem_rd == src)) begin
            pick_source = `FWD_MEM;
        end else if (wb_write_en && (wb_rd != '0) && (wb_rd == src)) begin
            pick_source = `FWD_WB;
        end else begin
            pick_source = `FWD_PIPE;
        end
    endfunction

    always_comb begin
        fwd_a = pick_source(exe_rs);
        fwd_b = pick_source(exe_rt);
    end

    // Load in execute feeding the instruction in decode
    // sw data skips this, it is patched from writeback in the memory stage
    assign stall = exe_is_load && (exe_rd != '0) &&
                   ((dec_rs == exe_rd) || ((dec_rt == exe_rd) && !dec_is_store));

    // Taken branch or jump squashes fetch/decode and decode/execute
    assign flush = redirect;

endmodule

/* processor.f */
+incdir+.
cpu_pkg.sv
decode_unit.sv
alu.sv
hazard_unit.sv
processor.sv
tb_checker.sv
tb_processor.sv

/* processor.sv */
// Five-stage pipelined processor
// Fetch, decode, execute, memory and writeback with forwarding, a one-cycle
// load-use stall and branches resolved in execute. Memories and the register
// file sit outside and are driven through the ports
`timescale 1ns/1ps
`include "cpu_config.svh"

module processor (
    input  logic              clock,
    input  logic              rst,
    // Instruction memory
    output cpu_pkg::word_t    address_imem,
    input  cpu_pkg::word_t    q_imem,
    // Data memory
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data,
    output logic              wren,
    input  cpu_pkg::word_t    q_dmem,
    // Register file
    output logic              ctrl_write_enable,
    output cpu_pkg::reg_idx_t ctrl_write_reg,
    output cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output cpu_pkg::reg_idx_t ctrl_read_reg_b,
    output cpu_pkg::word_t    data_write_reg,
    input  cpu_pkg::word_t    data_read_reg_a,
    input  cpu_pkg::word_t    data_read_reg_b
);

    // Fetch and decode
    cpu_pkg::word_t    pc, pc_next, redirect_target;
    cpu_pkg::word_t    fd_instr, fd_pc_next;
    cpu_pkg::reg_idx_t dec_rd;
    cpu_pkg::word_t    dec_imm;
    logic dec_write_en, dec_is_load, dec_is_store, dec_is_branch, dec_is_jump;
    logic redirect, stall, flush;
    // Decode/execute bank
    cpu_pkg::word_t    de_instr, de_pc_next, de_a, de_b, de_imm;
    cpu_pkg::reg_idx_t de_rs, de_rt, de_rd;
    logic de_write_en, de_is_load, de_is_store, de_is_branch, de_is_jump;
    // Execute
    cpu_pkg::opcode_t  exe_opcode;
    cpu_pkg::alu_fn_t  exe_fn;
    cpu_pkg::fwd_sel_t fwd_a, fwd_b;
    cpu_pkg::word_t    exe_a, exe_b, alu_b, alu_result, jump_target;
    logic exe_use_imm, not_equal, less_than;
    // Execute/memory and memory/writeback banks
    cpu_pkg::word_t    mem_alu, mem_store_data, wb_alu, wb_load;
    cpu_pkg::reg_idx_t mem_rd, mem_rt, wb_rd;
    logic mem_write_en, mem_is_load, mem_is_store, wb_write_en, wb_is_load;

    // 3:1 operand source mux
    function automatic cpu_pkg::word_t fwd_pick(input cpu_pkg::fwd_sel_t sel,
                                                input cpu_pkg::word_t pipe_val,
                                                input cpu_pkg::word_t mem_val,
                                                input cpu_pkg::word_t wb_val);
        case (sel)
            `FWD_MEM: fwd_pick = mem_val;
            `FWD_WB:  fwd_pick = wb_val;
            default:  fwd_pick = pipe_val;
        endcase
    endfunction

    assign address_imem = pc;
    assign pc_next      = pc + cpu_pkg::word_t'(1);

    // Redirect beats stall; stall holds the PC
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirect_target;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // All-zero word decodes as add r0, a bubble
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            fd_instr <= '0;
        end else if (!stall) begin
            fd_instr <= q_imem;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_pc_next <= pc_next;
        end
    end

    decode_unit u_decode (
        .instr      (fd_instr),
        .read_reg_a (ctrl_read_reg_a),
        .read_reg_b (ctrl_read_reg_b),
        .dest_reg   (dec_rd),
        .imm        (dec_imm),
        .write_en   (dec_write_en),
        .is_load    (dec_is_load),
        .is_store   (dec_is_store),
        .is_branch  (dec_is_branch)
    );

    assign dec_is_jump = (fd_instr[`FLD_OPCODE +: `CPU_OP_BITS] == `OP_J);

    // Decode/execute control, bubble on flush or load-use stall
    always_ff @(posedge clock) begin
        if (rst || flush || stall) begin
            de_write_en  <= 1'b0;
            de_is_load   <= 1'b0;
            de_is_store  <= 1'b0;
            de_is_branch <= 1'b0;
            de_is_jump   <= 1'b0;
        end else begin
            de_write_en  <= dec_write_en;
            de_is_load   <= dec_is_load;
            de_is_store  <= dec_is_store;
            de_is_branch <= dec_is_branch;
            de_is_jump   <= dec_is_jump;
        end
    end

    // Operands come from the write-through register file
    always_ff @(posedge clock) begin
        de_instr   <= fd_instr;
        de_pc_next <= fd_pc_next;
        de_a       <= data_read_reg_a;
        de_b       <= data_read_reg_b;
        de_imm     <= dec_imm;
        de_rs      <= ctrl_read_reg_a;
        de_rt      <= ctrl_read_reg_b;
        de_rd      <= dec_rd;
    end

    assign exe_opcode  = de_instr[`FLD_OPCODE +: `CPU_OP_BITS];
    // Non R-type instructions add, addresses included
    assign exe_fn      = (exe_opcode == `OP_ALU) ? de_instr[`FLD_FN +: `CPU_FN_BITS] : `ALU_ADD;
    assign exe_use_imm = (exe_opcode == `OP_ADDI) || de_is_load || de_is_store;

    assign exe_a = fwd_pick(fwd_a, de_a, mem_alu, data_write_reg);
    assign exe_b = fwd_pick(fwd_b, de_b, mem_alu, data_write_reg);
    assign alu_b = exe_use_imm ? de_imm : exe_b;

    alu u_alu (
        .operand_a (exe_a),
        .operand_b (alu_b),
        .fn        (exe_fn),
        .shamt     (de_instr[`FLD_SHAMT +: `CPU_REG_BITS]),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // Branch target is PC+1+imm, jump target is the zero-padded field
    assign jump_target     = {{(`CPU_XLEN - `CPU_TGT_BITS){1'b0}}, de_instr[`CPU_TGT_BITS-1:0]};
    assign redirect_target = de_is_jump ? jump_target : de_pc_next + de_imm;
    assign redirect        = de_is_jump ||
                             (de_is_branch && ((exe_opcode == `OP_BNE) ? not_equal : less_than));

    hazard_unit u_hazard (
        .dec_rs       (ctrl_read_reg_a),
        .dec_rt       (ctrl_read_reg_b),
        .exe_rs       (de_rs),
        .exe_rt       (de_rt),
        .exe_rd       (de_rd),
        .mem_rd       (mem_rd),
        .wb_rd        (wb_rd),
        .dec_is_store (dec_is_store),
        .exe_is_load  (de_is_load),
        .mem_write_en (mem_write_en),
        .wb_write_en  (wb_write_en),
        .redirect     (redirect),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .stall        (stall),
        .flush        (flush)
    );

    // Execute/memory and memory/writeback control
    always_ff @(posedge clock) begin
        if (rst) begin
            mem_write_en <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
            wb_write_en  <= 1'b0;
            wb_is_load   <= 1'b0;
        end else begin
            mem_write_en <= de_write_en;
            mem_is_load  <= de_is_load;
            mem_is_store <= de_is_store;
            wb_write_en  <= mem_write_en;
            wb_is_load   <= mem_is_load;
        end
    end

    always_ff @(posedge clock) begin
        mem_alu        <= alu_result;
        mem_store_data <= exe_b;
        mem_rd         <= de_rd;
        mem_rt         <= de_rt;
        wb_alu         <= mem_alu;
        wb_load        <= q_dmem;
        wb_rd          <= mem_rd;
    end

    // Store data from a lw just ahead is patched in from writeback
    assign address_dmem = mem_alu;
    assign data         = (wb_write_en && (wb_rd == mem_rt)) ? data_write_reg : mem_store_data;
    assign wren         = mem_is_store;

    assign ctrl_write_enable = wb_write_en;
    assign ctrl_write_reg    = wb_rd;
    assign data_write_reg    = wb_is_load ? wb_load : wb_alu;

endmodule

/* tb_checker.sv */
// Processor testbench checker
// Compares the register-write and store streams seen on the DUT ports
// against the expected streams in program order, and checks reset and fill
`timescale 1ns/1ps

module tb_checker (
    input logic              clock,
    input logic              rst,
    input cpu_pkg::word_t    address_imem,
    input logic              ctrl_write_enable,
    input cpu_pkg::reg_idx_t ctrl_write_reg,
    input cpu_pkg::word_t    data_write_reg,
    input logic              wren,
    input cpu_pkg::word_t    address_dmem,
    input cpu_pkg::word_t    data
);

    // Expected streams, loaded from the reference run before reset ends
    cpu_pkg::reg_idx_t exp_reg_q[$];
    cpu_pkg::word_t    exp_val_q[$];
    cpu_pkg::word_t    exp_addr_q[$];
    cpu_pkg::word_t    exp_data_q[$];

    int error_count = 0;
    int write_count = 0;
    int store_count = 0;
    int reset_edges = 0;
    // Rising edges since reset release, counted up to the first writeback
    int fill_cycles = 0;

    task automatic add_write(input cpu_pkg::reg_idx_t idx, input cpu_pkg::word_t val);
        exp_reg_q.push_back(idx);
        exp_val_q.push_back(val);
    endtask

    task automatic add_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t value);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(value);
    endtask

    function automatic int pending();
        return exp_reg_q.size() + exp_addr_q.size();
    endfunction

    task automatic check_write();
        cpu_pkg::reg_idx_t exp_reg;
        cpu_pkg::word_t    exp_val;
        if (ctrl_write_reg == '0) begin
            $display("Register zero was written with %h at %0t", data_write_reg, $time);
            error_count++;
        end
        if (exp_reg_q.size() == 0) begin
            $display("Extra register write to r%0d at %0t, none was expected",
                     ctrl_write_reg, $time);
            error_count++;
        end else begin
            exp_reg = exp_reg_q.pop_front();
            exp_val = exp_val_q.pop_front();
            if (ctrl_write_reg != exp_reg) begin
                $display("[ERROR] ctrl_write_reg: got %h, expected %h", ctrl_write_reg, exp_reg);
                error_count++;
            end
            if (data_write_reg != exp_val) begin
                $display("[ERROR] data_write_reg: got %h, expected %h", data_write_reg, exp_val);
                error_count++;
            end
            write_count++;
        end
    endtask

    task automatic check_store();
        cpu_pkg::word_t exp_addr;
        cpu_pkg::word_t exp_data;
        if (exp_addr_q.size() == 0) begin
            $display("Extra store to address %h at %0t, none was expected", address_dmem, $time);
            error_count++;
        end else begin
            exp_addr = exp_addr_q.pop_front();
            exp_data = exp_data_q.pop_front();
            if (address_dmem != exp_addr) begin
                $display("[ERROR] address_dmem: got %h, expected %h", address_dmem, exp_addr);
                error_count++;
            end
            if (data != exp_data) begin
                $display("[ERROR] data: got %h, expected %h", data, exp_data);
                error_count++;
            end
            store_count++;
        end
    endtask

    always @(posedge clock) begin
        if (rst) begin
            reset_edges <= reset_edges + 1;
            fill_cycles <= 0;
        end else if (fill_cycles < 4) begin
            fill_cycles <= fill_cycles + 1;
        end
    end

    // Outputs only move on the rising edge, so sample on the falling one
    always @(negedge clock) begin
        if (rst) begin
            // PC and strobes hold their reset values after the first edge
            if (reset_edges > 0 && address_imem != '0) begin
                $display("[ERROR] address_imem: got %h, expected %h", address_imem, 32'h0);
                error_count++;
            end
            if (reset_edges > 0 && (wren || ctrl_write_enable)) begin
                $display("A store or register write strobe was high during reset");
                error_count++;
            end
        end else begin
            // First instruction reaches memory on the third edge, writeback on the fourth
            if (fill_cycles < 3 && wren) begin
                $display("A store strobe rose before the pipeline had filled");
                error_count++;
            end
            if (fill_cycles < 4 && ctrl_write_enable) begin
                $display("A register write strobe rose before the pipeline had filled");
                error_count++;
            end
            if (ctrl_write_enable) begin
                check_write();
            end
            if (wren) begin
                check_store();
            end
        end
    end

endmodule

/* tb_processor.sv */
// Processor testbench top
// Memory and register-file models around the DUT, a random program from an
// xorshift generator, an ISA reference model and the closing report
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_processor;

    localparam int PROG_LEN     = 200;
    localparam int LAST         = PROG_LEN - 1;
    localparam int RUN_TIMEOUT  = 3000;
    localparam int DRAIN_CYCLES = 10;

    logic              clock = 1'b0;
    logic              rst = 1'b1;
    cpu_pkg::word_t    q_imem = '0;
    cpu_pkg::word_t    q_dmem = '0;
    cpu_pkg::word_t    data_read_reg_a = '0;
    cpu_pkg::word_t    data_read_reg_b = '0;
    cpu_pkg::word_t    address_imem, address_dmem, data, data_write_reg;
    logic              wren, ctrl_write_enable;
    cpu_pkg::reg_idx_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;

    // Models seen by the DUT, and the separate reference state
    cpu_pkg::word_t imem [0:PROG_LEN-1];
    cpu_pkg::word_t dmem [0:255];
    cpu_pkg::word_t regs [0:31];
    cpu_pkg::word_t ref_dmem [0:255];
    cpu_pkg::word_t ref_regs [0:31];
    logic [31:0]    rng_state;
    int             tb_errors = 0;

    always #10 clock = ~clock;

    processor u_dut (
        .clock             (clock),
        .rst               (rst),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    tb_checker u_check (
        .clock             (clock),
        .rst               (rst),
        .address_imem      (address_imem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg),
        .wren              (wren),
        .address_dmem      (address_dmem),
        .data              (data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int next_rand(input int bound);
        rng_state = xorshift(rng_state);
        return int'(rng_state % bound);
    endfunction

    // Random instruction at idx, branches and jumps only go forward
    function automatic cpu_pkg::word_t gen_instr(input int idx);
        int                kind;
        int                room;
        int                off;
        cpu_pkg::reg_idx_t rd, rs, rt;
        kind = next_rand(10);
        // Few registers, so neighbours often depend on each other
        rd   = 5'(next_rand(8));
        rs   = 5'(next_rand(8));
        rt   = 5'(next_rand(8));
        room = LAST - idx - 1;
        off  = next_rand(4);
        if (off > room) begin
            off = room;
        end
        if (kind < 4) begin
            return {`OP_ALU, rd, rs, rt, 5'(next_rand(32)), 5'(next_rand(6)), 2'b00};
        end else if (kind < 6) begin
            return {`OP_ADDI, rd, rs, 17'(next_rand(131072))};
        end else if (kind == 6) begin
            return {`OP_LW, rd, 5'd0, 17'(next_rand(32))};
        end else if (kind == 7) begin
            return {`OP_SW, rd, 5'd0, 17'(next_rand(32))};
        end else if (kind == 8) begin
            return {((next_rand(2) == 0) ? `OP_BNE : `OP_BLT), rd, rs, 17'(off)};
        end
        return {`OP_J, 27'(idx + 1 + off)};
    endfunction

    // ISA model of one instruction on the reference state, returns the next PC
    function automatic cpu_pkg::word_t ref_step(input cpu_pkg::word_t pc,
                                                output logic wr,
                                                output cpu_pkg::reg_idx_t wr_reg,
                                                output cpu_pkg::word_t wr_val,
                                                output logic st,
                                                output cpu_pkg::word_t st_addr,
                                                output cpu_pkg::word_t st_data);
        cpu_pkg::word_t    ins, va, vb, imm;
        cpu_pkg::opcode_t  op;
        cpu_pkg::alu_fn_t  fn;
        cpu_pkg::reg_idx_t rd, rs, rt, sh;
        ins     = imem[pc[7:0]];
        op      = ins[31:27];
        rd      = ins[26:22];
        rs      = ins[21:17];
        rt      = ins[16:12];
        sh      = ins[11:7];
        fn      = ins[6:2];
        imm     = {{15{ins[16]}}, ins[16:0]};
        va      = ref_regs[rs];
        vb      = ref_regs[rt];
        wr      = 1'b0;
        st      = 1'b0;
        wr_reg  = rd;
        wr_val  = '0;
        st_addr = va + imm;
        st_data = ref_regs[rd];
        ref_step = pc + 1;
        case (op)
            `OP_ALU: begin
                wr = 1'b1;
                case (fn)
                    `ALU_ADD: wr_val = va + vb;
                    `ALU_SUB: wr_val = va - vb;
                    `ALU_AND: wr_val = va & vb;
                    `ALU_OR:  wr_val = va | vb;
                    `ALU_SLL: wr_val = va << sh;
                    `ALU_SRA: wr_val = cpu_pkg::word_t'($signed(va) >>> sh);
                    default:  wr_val = '0;
                endcase
            end
            `OP_ADDI: begin
                wr     = 1'b1;
                wr_val = va + imm;
            end
            `OP_LW: begin
                wr     = 1'b1;
                wr_val = ref_dmem[st_addr[7:0]];
            end
            `OP_SW: begin
                st = 1'b1;
                ref_dmem[st_addr[7:0]] = st_data;
            end
            // Branches compare rd against rs
            `OP_BNE: if (st_data != va) ref_step = pc + 1 + imm;
            `OP_BLT: if ($signed(st_data) < $signed(va)) ref_step = pc + 1 + imm;
            `OP_J:   ref_step = {5'd0, ins[26:0]};
            default: ;
        endcase
        if (rd == '0) begin
            wr = 1'b0;
        end
        if (wr) begin
            ref_regs[rd] = wr_val;
        end
    endfunction

    // Write-through read, r0 always zero
    function automatic cpu_pkg::word_t reg_read(input cpu_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (ctrl_write_enable && ctrl_write_reg == idx) begin
            return data_write_reg;
        end
        return regs[idx];
    endfunction

    // Reads answer the current cycle, then this cycle's writes commit
    always @(negedge clock) begin
        q_imem = (address_imem < cpu_pkg::word_t'(PROG_LEN)) ? imem[address_imem[7:0]] : '0;
        q_dmem = dmem[address_dmem[7:0]];
        data_read_reg_a = reg_read(ctrl_read_reg_a);
        data_read_reg_b = reg_read(ctrl_read_reg_b);
        if (!rst && ctrl_write_enable && ctrl_write_reg != '0) begin
            regs[ctrl_write_reg] = data_write_reg;
        end
        if (!rst && wren) begin
            dmem[address_dmem[7:0]] = data;
        end
    end

    initial begin
        cpu_pkg::word_t    pc;
        cpu_pkg::reg_idx_t wr_reg;
        cpu_pkg::word_t    wr_val, st_addr, st_data;
        logic              wr, st;
        int                steps;
        int                cycles;
        rng_state = 32'd59;
        for (int k = 0; k < 32; k++) begin
            regs[k]     = (k == 0) ? '0 : cpu_pkg::word_t'(k) * 32'h0102_0409 ^ 32'h8000_0000;
            ref_regs[k] = regs[k];
        end
        for (int a = 0; a < 256; a++) begin
            dmem[a]     = cpu_pkg::word_t'(a) * 32'h9E37_79B9 ^ 32'h0F0F_0000;
            ref_dmem[a] = dmem[a];
        end
        for (int n = 0; n < LAST; n++) begin
            imem[n] = gen_instr(n);
        end
        // Fixed opening with sw data taken straight from a lw, then a load-use stall
        imem[0] = {`OP_LW, 5'd1, 5'd0, 17'd3};
        imem[1] = {`OP_SW, 5'd1, 5'd0, 17'd7};
        imem[2] = {`OP_LW, 5'd4, 5'd0, 17'd11};
        imem[3] = {`OP_ADDI, 5'd5, 5'd4, 17'd1};
        // Program ends on a jump to itself
        imem[LAST] = {`OP_J, 27'(LAST)};

        // Expected streams in program order
        pc    = '0;
        steps = 0;
        while (pc != cpu_pkg::word_t'(LAST) && steps < PROG_LEN) begin
            pc = ref_step(pc, wr, wr_reg, wr_val, st, st_addr, st_data);
            if (wr) begin
                u_check.add_write(wr_reg, wr_val);
            end
            if (st) begin
                u_check.add_store(st_addr, st_data);
            end
            steps++;
        end

        for (int c = 0; c < 4; c++) begin
            @(negedge clock);
        end
        rst <= 1'b0;

        // Run until fetch parks on the final jump and every entry is seen
        cycles = 0;
        while (!(address_imem == cpu_pkg::word_t'(LAST) && u_check.pending() == 0) &&
               cycles < RUN_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (cycles >= RUN_TIMEOUT) begin
            $display("Timeout after %0d cycles, the program end was not reached", cycles);
            tb_errors++;
        end
        // Extra cycles so late spurious writes still get caught
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            @(posedge clock);
        end
        if (u_check.pending() != 0) begin
            $display("%0d expected writes or stores were never observed", u_check.pending());
            tb_errors++;
        end

        $display("Closing report: %0d writes, %0d stores checked, %0d errors",
                 u_check.write_count, u_check.store_count, u_check.error_count + tb_errors);
        if (u_check.error_count == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
